//--- all.f
+incdir+.
ls_pkg.sv
ls_input_fifo.sv
ls_scratch_ram.sv
ls_bus_master.sv
ls_load_align.sv
load_store_unit.sv
ls_subsystem_top.sv
tb_ls.sv

//--- load_store_unit.sv
////////////////////////////////////////////////////////////
// Load/store unit: buffers requests, checks alignment,
// steers each access to scratch RAM or the external bus by
// address, and returns load data, store commits and
// misalignment exceptions as single-cycle pulses.
////////////////////////////////////////////////////////////

`default_nettype none
`include "ls_defines.svh"

module load_store_unit import ls_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  ls_request_t   req,
    input  logic          req_valid,
    output logic          req_ready,
    output ls_writeback_t wb,
    output logic          wb_valid,
    output ls_exception_t exc,
    output logic          exc_valid,
    output logic          store_committed,
    output ls_id_t        store_id,
    output ls_bus_req_t   bus_req,
    output logic          bus_valid,
    input  logic          bus_ack,
    input  logic [31:0]   bus_rdata
);

    typedef struct packed {
        ls_id_t     id;
        logic [2:0] fn3;
        logic [1:0] byte_offset;
    } load_attr_t;

    ls_request_t head;
    ls_sub_req_t sub_req;
    logic        head_valid, fifo_full, fifo_pop;
    logic        misaligned, issue, current_bus, last_bus;
    logic        unit_stall, forward_stall, sel_ready;
    logic        ram_ready, ram_data_valid, bus_ready, bus_data_valid;
    logic [31:0] ram_data, bus_data, load_word, aligned_data;
    logic [31:0] previous_load, raw_store_data;
    logic [3:0]  be;
    logic        load_complete;
    load_attr_t  attr_q [2];
    load_attr_t  attr_head;
    logic        attr_wr_ptr, attr_rd_ptr;
    logic [1:0]  attr_count;

    ls_input_fifo input_fifo_i (
        .clk, .rst,
        .push     (req_valid & req_ready),
        .data_in  (req),
        .pop      (fifo_pop),
        .data_out (head),
        .valid    (head_valid),
        .full     (fifo_full)
    );

    assign req_ready = ~fifo_full;

    ////////////////////////////////////////////////////////////
    // Issue control
    always_comb begin
        case (head.fn3[1:0])
            LS_H[1:0]: misaligned = head.addr[0];
            LS_W[1:0]: misaligned = |head.addr[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    assign current_bus = head.addr[`LS_BUS_SELECT_BIT];
    assign sel_ready   = current_bus ? bus_ready : ram_ready;
    // Switching units with loads in flight could reorder results
    assign unit_stall    = (current_bus != last_bus) && (attr_count != 2'd0);
    assign forward_stall = head.store && head.forward && (attr_count != 2'd0);
    assign issue    = head_valid & ~misaligned & sel_ready & ~unit_stall & ~forward_stall;
    assign fifo_pop = issue | (head_valid & misaligned);

    always_ff @(posedge clk) begin
        if (rst)
            last_bus <= 1'b0;
        else if (issue && head.load)
            last_bus <= current_bus;
    end

    ////////////////////////////////////////////////////////////
    // Store lanes
    always_comb begin
        case (head.fn3[1:0])
            LS_B[1:0]: be = 4'b0001 << head.addr[1:0];
            LS_H[1:0]: be = head.addr[1] ? 4'b1100 : 4'b0011;
            default:   be = 4'b1111;
        endcase
        be = be & {4{head.store}};
    end

    assign raw_store_data = head.forward ? previous_load : head.wdata;

    always_comb begin
        sub_req.addr = head.addr;
        sub_req.be   = be;
        sub_req.we   = head.store;
        case (head.fn3[1:0])
            LS_B[1:0]: sub_req.wdata = {4{raw_store_data[7:0]}};
            LS_H[1:0]: sub_req.wdata = {2{raw_store_data[15:0]}};
            default:   sub_req.wdata = raw_store_data;
        endcase
    end

    ls_scratch_ram scratch_i (
        .clk, .rst,
        .new_request (issue & ~current_bus),
        .sub_req,
        .ready       (ram_ready),
        .data_valid  (ram_data_valid),
        .data_out    (ram_data)
    );

    ls_bus_master bus_master_i (
        .clk, .rst,
        .new_request (issue & current_bus),
        .sub_req,
        .ready       (bus_ready),
        .data_valid  (bus_data_valid),
        .data_out    (bus_data),
        .bus_req, .bus_valid, .bus_ack, .bus_rdata
    );

    ////////////////////////////////////////////////////////////
    // Load attributes, in issue order
    assign load_complete = ram_data_valid | bus_data_valid;
    assign attr_head     = attr_q[attr_rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            attr_wr_ptr <= 1'b0;
            attr_rd_ptr <= 1'b0;
            attr_count  <= 2'd0;
        end else begin
            if (issue && head.load)
                attr_wr_ptr <= ~attr_wr_ptr;
            if (load_complete)
                attr_rd_ptr <= ~attr_rd_ptr;
            attr_count <= attr_count + 2'(issue & head.load) - 2'(load_complete);
        end
    end

    always_ff @(posedge clk) begin
        if (issue && head.load)
            attr_q[attr_wr_ptr] <= '{id: head.id, fn3: head.fn3, byte_offset: head.addr[1:0]};
    end

    // Idle sub-units drive zero
    assign load_word = ram_data | bus_data;

    ls_load_align load_align_i (
        .word        (load_word),
        .byte_offset (attr_head.byte_offset),
        .fn3         (attr_head.fn3),
        .data        (aligned_data)
    );

    ////////////////////////////////////////////////////////////
    // Result outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid        <= 1'b0;
            exc_valid       <= 1'b0;
            store_committed <= 1'b0;
        end else begin
            wb_valid        <= load_complete;
            exc_valid       <= head_valid & misaligned;
            store_committed <= issue & head.store;
        end
    end

    always_ff @(posedge clk) begin
        wb.id     <= attr_head.id;
        wb.data   <= aligned_data;
        exc.id    <= head.id;
        exc.addr  <= head.addr;
        exc.store <= head.store;
        store_id  <= head.id;
        if (load_complete)
            previous_load <= aligned_data;
    end

endmodule

`default_nettype wire

//--- ls_bus_master.sv
////////////////////////////////////////////////////////////
// Request/acknowledge bus master. One transaction at a time:
// bus_valid holds from the cycle after issue until bus_ack,
// and read data is passed back in the acknowledge cycle.
////////////////////////////////////////////////////////////

`default_nettype none

module ls_bus_master import ls_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        new_request,
    input  ls_sub_req_t sub_req,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data_out,
    output ls_bus_req_t bus_req,
    output logic        bus_valid,
    input  logic        bus_ack,
    input  logic [31:0] bus_rdata
);

    always_ff @(posedge clk) begin
        if (rst)
            bus_valid <= 1'b0;
        else if (new_request)
            bus_valid <= 1'b1;
        else if (bus_ack)
            bus_valid <= 1'b0;
    end

    // Request is held stable while bus_valid is up
    always_ff @(posedge clk) begin
        if (new_request) begin
            bus_req.addr  <= sub_req.addr;
            bus_req.be    <= sub_req.be;
            bus_req.wdata <= sub_req.wdata;
            bus_req.we    <= sub_req.we;
        end
    end

    // Busy until the cycle after the acknowledge
    assign ready = ~bus_valid;

    // Writes finish without a return
    assign data_valid = bus_valid & bus_ack & ~bus_req.we;
    assign data_out   = data_valid ? bus_rdata : 32'd0;

endmodule

`default_nettype wire

//--- ls_defines.svh
////////////////////////////////////////////////////////////
// Build-time sizes and address map of the load/store unit.
// Include in any module that sizes storage or decodes
// addresses.
////////////////////////////////////////////////////////////

`ifndef LS_DEFINES_SVH
`define LS_DEFINES_SVH

// Pending requests held ahead of issue
`define LS_FIFO_DEPTH 4

// Scratch RAM size in 32-bit words
`define LS_SCRATCH_WORDS 256

// Set in a physical address, the access goes to the bus
`define LS_BUS_SELECT_BIT 31

`endif

//--- ls_input.mem
// op(1 load 2 store) id fn3 fwd kind(0 commit 1 writeback 2 exception)
// then addr, store data, expected load result
2_0_2_0_0_00000040_11223344_00000000
1_1_2_0_1_00000040_00000000_11223344
2_2_2_0_0_80000100_cafef00d_00000000
1_3_2_0_1_80000100_00000000_cafef00d
2_4_0_0_0_00000041_000000aa_00000000
2_5_0_0_0_00000043_000000bb_00000000
2_6_1_0_0_00000040_00009988_00000000
1_7_2_0_1_00000040_00000000_bb229988
2_0_0_0_0_00000042_00000080_00000000
2_1_0_0_0_00000040_000000f1_00000000
2_2_1_0_0_00000042_0000fe7c_00000000
1_3_2_0_1_00000040_00000000_fe7c99f1
1_4_0_0_1_00000040_00000000_fffffff1
1_5_4_0_1_00000041_00000000_00000099
1_6_1_0_1_00000042_00000000_fffffe7c
1_7_5_0_1_00000040_00000000_000099f1
1_0_0_0_1_00000042_00000000_0000007c
1_1_1_0_2_00000041_00000000_00000000
2_2_2_0_2_80000102_00000000_00000000
2_3_2_1_0_80000104_00000000_00000000
1_4_2_0_1_80000104_00000000_0000007c
1_5_2_0_1_80000100_00000000_cafef00d
1_6_2_0_1_00000040_00000000_fe7c99f1
1_7_5_0_1_80000102_00000000_0000cafe
2_0_2_0_0_80000108_12345678_00000000
2_1_2_0_0_8000010c_9abcdef0_00000000
1_2_2_0_1_80000108_00000000_12345678
1_3_4_0_1_8000010f_00000000_0000009a

//--- ls_input_fifo.sv
////////////////////////////////////////////////////////////
// Circular buffer of pending load/store requests.
// The head entry is visible on data_out while valid is high;
// push must not be raised while full.
////////////////////////////////////////////////////////////

`default_nettype none
`include "ls_defines.svh"

module ls_input_fifo import ls_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  ls_request_t data_in,
    input  logic        pop,
    output ls_request_t data_out,
    output logic        valid,
    output logic        full
);

    localparam int DEPTH = `LS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ls_request_t entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= data_in;
    end

    assign data_out = entries[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- ls_load_align.sv
////////////////////////////////////////////////////////////
// Picks the addressed byte or halfword out of a loaded word
// and extends it to 32 bits as the fn3 field asks.
////////////////////////////////////////////////////////////

`default_nettype none

module ls_load_align import ls_pkg::*; (
    input  logic [31:0] word,
    input  logic [1:0]  byte_offset,
    input  logic [2:0]  fn3,
    output logic [31:0] data
);

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    // Halfword first, then the byte within it
    assign half_sel = byte_offset[1] ? word[31:16] : word[15:0];
    assign byte_sel = byte_offset[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (fn3)
            LS_B:    data = {{24{byte_sel[7]}}, byte_sel};
            LS_H:    data = {{16{half_sel[15]}}, half_sel};
            LS_BU:   data = {24'd0, byte_sel};
            LS_HU:   data = {16'd0, half_sel};
            default: data = word;
        endcase
    end

endmodule

`default_nettype wire

//--- ls_pkg.sv
////////////////////////////////////////////////////////////
// Types and fn3 encodings shared by the load/store blocks.
// Modules take them with a wildcard import in the header.
////////////////////////////////////////////////////////////

`default_nettype none

package ls_pkg;

    typedef logic [2:0] ls_id_t;

    // Width field of the load/store opcode
    localparam logic [2:0] LS_B  = 3'b000;
    localparam logic [2:0] LS_H  = 3'b001;
    localparam logic [2:0] LS_W  = 3'b010;
    localparam logic [2:0] LS_BU = 3'b100;
    localparam logic [2:0] LS_HU = 3'b101;

    typedef struct packed {
        ls_id_t      id;
        logic        load;
        logic        store;
        logic [2:0]  fn3;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        forward;
    } ls_request_t;

    // Same request goes to every sub-unit
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        we;
    } ls_sub_req_t;

    typedef struct packed {
        ls_id_t      id;
        logic [31:0] data;
    } ls_writeback_t;

    typedef struct packed {
        ls_id_t      id;
        logic [31:0] addr;
        logic        store;
    } ls_exception_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        we;
    } ls_bus_req_t;

endpackage

`default_nettype wire

//--- ls_scratch_ram.sv
////////////////////////////////////////////////////////////
// Local data RAM with byte-enable writes. A read returns the
// word one cycle after the request; otherwise data_out is 0
// so it can be OR-ed with the other sub-unit.
////////////////////////////////////////////////////////////

`default_nettype none
`include "ls_defines.svh"

module ls_scratch_ram import ls_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        new_request,
    input  ls_sub_req_t sub_req,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data_out
);

    localparam int IDX_W = $clog2(`LS_SCRATCH_WORDS);

    logic [31:0] mem [`LS_SCRATCH_WORDS];
    logic [31:0] read_word;
    logic [IDX_W-1:0] idx;

    assign idx = sub_req.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (new_request && sub_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (sub_req.be[i])
                    mem[idx][8*i +: 8] <= sub_req.wdata[8*i +: 8];
            end
        end
        read_word <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            data_valid <= 1'b0;
        else
            data_valid <= new_request & ~sub_req.we;
    end

    assign data_out = data_valid ? read_word : 32'd0;
    assign ready    = 1'b1;

endmodule

`default_nettype wire

//--- ls_subsystem_top.sv
////////////////////////////////////////////////////////////
// Top level of the load/store subsystem. Connects the unit
// to the issue stage, the result paths and the external bus.
////////////////////////////////////////////////////////////

`default_nettype none

module ls_subsystem_top import ls_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  ls_request_t   req,
    input  logic          req_valid,
    output logic          req_ready,
    output ls_writeback_t wb,
    output logic          wb_valid,
    output ls_exception_t exc,
    output logic          exc_valid,
    output logic          store_committed,
    output ls_id_t        store_id,
    output ls_bus_req_t   bus_req,
    output logic          bus_valid,
    input  logic          bus_ack,
    input  logic [31:0]   bus_rdata
);

    load_store_unit lsu_i (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .wb              (wb),
        .wb_valid        (wb_valid),
        .exc             (exc),
        .exc_valid       (exc_valid),
        .store_committed (store_committed),
        .store_id        (store_id),
        .bus_req         (bus_req),
        .bus_valid       (bus_valid),
        .bus_ack         (bus_ack),
        .bus_rdata       (bus_rdata)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f all.f --top-module tb_ls -o tb_ls_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ls_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1

//--- tb_ls.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the load/store subsystem.
// Requests and expected results come from ls_input.mem; a
// bus memory model answers with a random delay. Run from
// the project root.
////////////////////////////////////////////////////////////

`default_nettype none
`include "ls_defines.svh"

module tb_ls import ls_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    // One line of the data file
    typedef struct packed {
        logic [3:0]  op;
        logic [3:0]  id;
        logic [3:0]  fn3;
        logic [3:0]  fwd;
        logic [3:0]  kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expd;
    } vec_t;

    logic clk = 1'b0;
    logic rst, req_valid, req_ready, wb_valid, exc_valid, store_committed;
    logic bus_valid, bus_ack;
    logic [31:0] bus_rdata;
    ls_request_t req;
    ls_writeback_t wb;
    ls_exception_t exc;
    ls_id_t store_id;
    ls_bus_req_t bus_req;

    vec_t vecs [64];
    logic [31:0] bus_mem [256];
    ls_writeback_t wb_q [$];
    ls_exception_t exc_q [$];
    ls_id_t store_q [$];
    integer seed = 32'h53e6;
    int check_errors = 0;
    int other_errors = 0;
    int bus_delay = 0;
    logic bus_busy = 1'b0;
    logic saw_full = 1'b0;

    ls_subsystem_top dut_i (.*);

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Bus memory model answering within 1 to 4 cycles
    always @(negedge clk) begin
        if (rst || bus_ack) begin
            bus_ack = 1'b0;
            bus_busy = 1'b0;
        end else if (bus_valid) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                bus_delay = int'($unsigned($random(seed)) % 32'd4);
            end else if (bus_delay != 0)
                bus_delay--;
            if (bus_delay == 0) begin
                bus_ack = 1'b1;
                bus_rdata = bus_mem[bus_req.addr[9:2]];
                for (int i = 0; i < 4; i++) begin
                    if (bus_req.we && bus_req.be[i])
                        bus_mem[bus_req.addr[9:2]][8*i +: 8] = bus_req.wdata[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Result monitor sampling outputs mid-cycle
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            assert (wb_q.size() != 0) else begin
                other_errors++;
                $display("Unexpected writeback for id %0d at time %0t", wb.id, $time);
            end
            if (wb_q.size() != 0) begin
                assert (wb == wb_q[0]) else begin
                    check_errors++;
                    $display({"CHECK FAILED at %0t: writeback id %0d data %h,",
                              " expected id %0d data %h"},
                             $time, wb.id, wb.data, wb_q[0].id, wb_q[0].data);
                end
                void'(wb_q.pop_front());
            end
        end
        if (!rst && store_committed) begin
            assert (store_q.size() != 0) else begin
                other_errors++;
                $display("Unexpected store commit for id %0d at time %0t", store_id, $time);
            end
            if (store_q.size() != 0) begin
                assert (store_id == store_q[0]) else begin
                    check_errors++;
                    $display("CHECK FAILED at %0t: store commit id %0d, expected %0d",
                             $time, store_id, store_q[0]);
                end
                void'(store_q.pop_front());
            end
        end
        if (!rst && exc_valid) begin
            assert (exc_q.size() != 0) else begin
                other_errors++;
                $display("Unexpected exception for id %0d at time %0t", exc.id, $time);
            end
            if (exc_q.size() != 0) begin
                assert (exc == exc_q[0]) else begin
                    check_errors++;
                    $display({"CHECK FAILED at %0t: exception id %0d addr %h,",
                              " expected id %0d addr %h"},
                             $time, exc.id, exc.addr, exc_q[0].id, exc_q[0].addr);
                end
                void'(exc_q.pop_front());
            end
        end
    end

    // Queue what the request must produce in request order
    task automatic add_expected(input vec_t v);
        case (v.kind)
            4'd0: store_q.push_back(v.id[2:0]);
            4'd1: wb_q.push_back('{id: v.id[2:0], data: v.expd});
            default: exc_q.push_back('{id: v.id[2:0], addr: v.addr, store: v.op == 4'd2});
        endcase
    endtask

    // Present one request and hold it until accepted
    task automatic send_request(input vec_t v);
        int waited;
        waited = 0;
        req = '{id: v.id[2:0], load: v.op == 4'd1, store: v.op == 4'd2, fn3: v.fn3[2:0],
                addr: v.addr, wdata: v.wdata, forward: v.fwd[0]};
        req_valid = 1'b1;
        while (!req_ready && waited < TIMEOUT) begin
            saw_full = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            other_errors++;
            $display("Request id %0d was never accepted", v.id);
        end else
            add_expected(v);
        @(negedge clk);
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while ((wb_q.size() + store_q.size() + exc_q.size()) != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            other_errors++;
            $display("Timed out waiting for outstanding results");
        end
    endtask

    // Last scratch load with no scratch store after it, or -1
    function automatic int last_scratch_load(input int count);
        int idx;
        idx = -1;
        for (int i = 0; i < count; i++) begin
            if (!vecs[i].addr[`LS_BUS_SELECT_BIT] && vecs[i].kind == 4'd1)
                idx = i;
            else if (!vecs[i].addr[`LS_BUS_SELECT_BIT] && vecs[i].kind == 4'd0)
                idx = -1;
        end
        return idx;
    endfunction

    // Idle scratch load whose writeback comes 2 cycles after issue
    task automatic measure_scratch_latency(input vec_t v);
        int cycles;
        send_request(v);
        req_valid = 1'b0;
        // One cycle has passed since the push
        cycles = 1;
        while (!wb_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_valid) begin
            other_errors++;
            $display("No writeback arrived for the timed scratch load");
        end else begin
            assert (cycles == 3) else begin
                check_errors++;
                $display("CHECK FAILED at %0t: scratch load took %0d cycles from push",
                         $time, cycles);
            end
        end
        drain_results();
    endtask

    initial begin
        int n;
        int latency_idx;
        req = '0;
        req_valid = 1'b0;
        bus_ack = 1'b0;
        bus_rdata = 32'd0;
        rst = 1'b1;
        for (int i = 0; i < 64; i++)
            vecs[i] = '0;
        for (int i = 0; i < 256; i++)
            bus_mem[i] = {8'h5a ^ i[7:0], i[7:0], ~i[7:0], 8'hc3 ^ i[7:0]};
        $readmemh("ls_input.mem", vecs);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (n < 64 && vecs[n].op != 4'd0) begin
            send_request(vecs[n]);
            n++;
        end
        req_valid = 1'b0;
        drain_results();
        latency_idx = last_scratch_load(n);
        if (latency_idx < 0) begin
            other_errors++;
            $display("The data file holds no scratch load to time");
        end else
            measure_scratch_latency(vecs[latency_idx]);
        assert (saw_full) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: req_ready never fell during the bus burst", $time);
        end
        $display("Errors: %0d check, %0d other", check_errors, other_errors);
        if (check_errors + other_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
